// ==== logic/usb_tx_pkg.sv ====
/*
 * Shared constants and enums for the full-speed USB packet transmitter.
 * The clock is 48 MHz and BitDiv sets the 12 MHz bit time.
 */

package usb_tx_pkg;

  // Clock cycles per bit time and the matching counter width
  localparam int unsigned BitDiv  = 4;
  localparam int unsigned BitCntW = $clog2(BitDiv);

  // Payload queue size
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned FifoPtrW  = $clog2(FifoDepth);
  localparam int unsigned FifoCntW  = $clog2(FifoDepth + 1);

  // SYNC as it leaves the shift register, LSB first
  localparam logic [7:0] SyncByte = 8'h80;

  localparam logic [15:0] Crc16Poly = 16'h8005;
  localparam logic [15:0] Crc16Init = 16'hFFFF;

  typedef enum logic [3:0] {
    Out   = 4'b0001,
    In    = 4'b1001,
    Sof   = 4'b0101,
    Setup = 4'b1101,
    Data0 = 4'b0011,
    Data1 = 4'b1011,
    Ack   = 4'b0010,
    Nak   = 4'b1010,
    Stall = 4'b1110
  } usb_pid_e;

  typedef enum logic [2:0] {Idle, Sync, Pid, DataOrCrcHi, CrcLo, Eop, OscTest} framer_state_e;

  typedef enum logic [1:0] {LsIdle, LsWaitByte, LsTransmit} line_state_e;

endpackage

// ==== logic/usb_tx_serial_if.sv ====
/*
 * Unencoded bit stream from the framer to the line driver.
 * All signals change only on the 48 MHz clock edge.
 */

`timescale 1ns/1ps

interface usb_tx_serial_if;

  // Current bit before NRZI, with its enable and SE0 marker
  logic bit_data;
  logic bit_oe;
  logic bit_se0;

  // One-cycle pulse when a packet or the test mode is launched
  logic frame_start;

  modport framer (
    output bit_data, bit_oe, bit_se0, frame_start
  );

  modport driver (
    input bit_data, bit_oe, bit_se0, frame_start
  );

endinterface

// ==== logic/usb_tx_bit_timer.sv ====
/*
 * Local 12 MHz bit strobe, standing in for the receiver's clock recovery.
 * Restart aligns the strobe so that the first one follows BitDiv cycles later.
 */

`timescale 1ns/1ps

module usb_tx_bit_timer import usb_tx_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic restart_i,
  output logic bit_strobe_o
);

  logic [BitCntW-1:0] cnt_q;
  logic               wrap;

  assign wrap = (cnt_q == BitCntW'(BitDiv - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      bit_strobe_o <= 1'b0;
    end else if (link_reset_i || restart_i) begin
      cnt_q        <= '0;
      bit_strobe_o <= 1'b0;
    end else begin
      bit_strobe_o <= wrap;
      cnt_q        <= wrap ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

// ==== logic/usb_tx_byte_fifo.sv ====
/*
 * Payload byte queue between host and framer. Writes while full are dropped.
 * The head entry is valid whenever rd_avail_o is high, and a get pops it.
 */

`timescale 1ns/1ps

module usb_tx_byte_fifo import usb_tx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       wr_valid_i,
  input  logic [7:0] wr_data_i,
  output logic       full_o,
  input  logic       rd_get_i,
  output logic       rd_avail_o,
  output logic [7:0] rd_data_o
);

  logic [7:0]          mem_q [FifoDepth];
  logic [FifoPtrW-1:0] wr_ptr_q;
  logic [FifoPtrW-1:0] rd_ptr_q;
  logic [FifoCntW-1:0] count_q;
  logic                wr_en;
  logic                rd_en;

  assign full_o     = (count_q == FifoCntW'(FifoDepth));
  assign rd_avail_o = (count_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];

  assign wr_en = wr_valid_i && !full_o;
  assign rd_en = rd_get_i && rd_avail_o;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (link_reset_i) begin
      // Flush whatever the host had queued
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== logic/usb_tx_framer.sv ====
/*
 * Packet framer: SYNC, PID, payload and CRC16 for data PIDs, then EOP.
 * A start is taken only in Idle. An empty queue mid-packet ends the payload.
 * Stuffing adds a zero after six ones and never consumes data.
 */

`timescale 1ns/1ps

module usb_tx_framer import usb_tx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       bit_strobe_i,
  input  logic       pkt_start_i,
  input  usb_pid_e   pid_i,
  input  logic       osc_test_i,
  input  logic       data_avail_i,
  input  logic [7:0] data_i,
  output logic       data_get_o,
  output logic       pkt_end_o,
  usb_tx_serial_if.framer ser
);

  framer_state_e state_q, state_d;
  usb_pid_e      pid_q;

  logic [7:0]  data_sr_q, data_sr_d;
  logic [7:0]  oe_sr_q, oe_sr_d;
  logic [7:0]  se0_sr_q, se0_sr_d;
  logic        payload_q, payload_d;
  logic        get_q, get_d;
  logic        byte_strobe_q, byte_strobe_d;
  logic [4:0]  hist_q, hist_d;
  logic [2:0]  count_q, count_d;
  logic [15:0] crc_q, crc_d;
  logic        stuffed_q;

  logic [5:0]  bit_history;
  logic        bitstuff;
  logic        start_ok;
  logic        test_mode_start;
  logic        crc_fb;

  assign start_ok = pkt_start_i && (state_q == Idle) && !osc_test_i;

  assign ser.bit_data    = data_sr_q[0];
  assign ser.bit_oe      = oe_sr_q[0];
  assign ser.bit_se0     = se0_sr_q[0];
  assign ser.frame_start = start_ok || test_mode_start;

  // Current bit plus the five before it
  assign bit_history = {data_sr_q[0], hist_q};
  assign bitstuff    = (bit_history == 6'b111111);

  // Strobe that shifts out the last SE0 bit
  assign pkt_end_o  = bit_strobe_i && (se0_sr_q[1:0] == 2'b01);
  assign data_get_o = get_q;

  ////////////////////////////////////////////////////////////////////////////
  // Packet FSM and serializer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    data_sr_d       = data_sr_q;
    oe_sr_d         = oe_sr_q;
    se0_sr_d        = se0_sr_q;
    payload_d       = payload_q;
    get_d           = 1'b0;
    hist_d          = hist_q;
    count_d         = count_q;
    test_mode_start = 1'b0;

    unique case (state_q)
      Idle: begin
        if (osc_test_i) begin
          state_d         = OscTest;
          test_mode_start = 1'b1;
        end else if (start_ok) begin
          state_d = Sync;
        end
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = SyncByte;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          // Only data PIDs carry payload and CRC
          state_d   = (pid_q[1:0] == 2'b11) ? DataOrCrcHi : Eop;
          data_sr_d = {~pid_q, pid_q};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      DataOrCrcHi: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hFF;
          se0_sr_d = 8'h00;
          if (data_avail_i) begin
            payload_d = 1'b1;
            get_d     = 1'b1;
            data_sr_d = data_i;
          end else begin
            state_d   = CrcLo;
            payload_d = 1'b0;
            data_sr_d = ~{crc_q[8], crc_q[9], crc_q[10], crc_q[11],
                          crc_q[12], crc_q[13], crc_q[14], crc_q[15]};
          end
        end
      end
      CrcLo: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = ~{crc_q[0], crc_q[1], crc_q[2], crc_q[3],
                        crc_q[4], crc_q[5], crc_q[6], crc_q[7]};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Eop: begin
        if (byte_strobe_q) begin
          // SE0, SE0, then the J bit shaped by the driver
          state_d   = Idle;
          data_sr_d = 8'h00;
          oe_sr_d   = 8'b0000_0111;
          se0_sr_d  = 8'b0000_0111;
        end
      end
      OscTest: begin
        if (byte_strobe_q) begin
          if (!osc_test_i) begin
            state_d = Idle;
            oe_sr_d = 8'h00;
          end else begin
            // All zeros toggle the line every bit
            data_sr_d = 8'h00;
            oe_sr_d   = 8'hFF;
            se0_sr_d  = 8'h00;
          end
        end
      end
      default: state_d = Idle;
    endcase

    // One bit time of gap before SYNC starts
    if (start_ok) begin
      count_d = 3'd7;
      hist_d  = '0;
    end else if (bit_strobe_i) begin
      hist_d = bit_history[5:1];
      if (bitstuff) begin
        data_sr_d[0] = 1'b0;
      end else begin
        count_d   = count_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !start_ok && (count_q == 3'd0);

  ////////////////////////////////////////////////////////////////////////////
  // CRC16 over payload bits, stuffed zeros skipped
  ////////////////////////////////////////////////////////////////////////////

  assign crc_fb = data_sr_q[0] ^ crc_q[15];

  always_comb begin
    crc_d = crc_q;
    if (start_ok) begin
      crc_d = Crc16Init;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^ ({16{crc_fb}} & Crc16Poly);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q     <= Out;
      stuffed_q <= 1'b0;
    end else if (link_reset_i) begin
      pid_q     <= Out;
      stuffed_q <= 1'b0;
    end else begin
      if (start_ok) begin
        pid_q <= pid_i;
      end
      // Marks the bit on the line as a stuffed zero until the next strobe
      if (start_ok) begin
        stuffed_q <= 1'b0;
      end else if (bit_strobe_i) begin
        stuffed_q <= bitstuff;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      count_q       <= '0;
      crc_q         <= '0;
    end else if (link_reset_i) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      count_q       <= '0;
      crc_q         <= '0;
    end else begin
      state_q       <= state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      payload_q     <= payload_d;
      get_q         <= get_d;
      byte_strobe_q <= byte_strobe_d;
      hist_q        <= hist_d;
      count_q       <= count_d;
      crc_q         <= crc_d;
    end
  end

endmodule

// ==== logic/usb_tx_line_driver.sv ====
/*
 * NRZI line driver with EOP shaping and D+/D- pin flip.
 * The line rests at J whenever the output is disabled. Pads are registered.
 */

`timescale 1ns/1ps

module usb_tx_line_driver import usb_tx_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic bit_strobe_i,
  input  logic cfg_pinflip_i,
  usb_tx_serial_if.driver ser,
  output logic usb_oe_o,
  output logic usb_d_o,
  output logic usb_se0_o,
  output logic usb_dp_o,
  output logic usb_dn_o
);

  line_state_e state_q, state_d;

  logic       nrzi_en;
  logic       oe_q, oe_d;
  logic       d_q, d_d;
  logic       se0_q, se0_d;
  logic [2:0] eop_q, eop_d;
  logic       dp_next;
  logic       dn_next;

  // Wait for the first byte after a launch, then follow the bit stream
  always_comb begin
    state_d = state_q;
    nrzi_en = 1'b0;
    unique case (state_q)
      LsIdle: begin
        if (ser.frame_start) begin
          state_d = LsWaitByte;
        end
      end
      LsWaitByte: begin
        if (ser.bit_oe) begin
          state_d = LsTransmit;
        end
      end
      LsTransmit: begin
        nrzi_en = 1'b1;
        if (bit_strobe_i && !ser.bit_oe) begin
          state_d = LsIdle;
        end
      end
      default: state_d = LsIdle;
    endcase
  end

  always_comb begin
    oe_d  = oe_q;
    d_d   = d_q;
    se0_d = se0_q;
    eop_d = eop_q;
    if (ser.frame_start) begin
      // Start from J so that the first SYNC bit is a K
      d_d   = 1'b1;
      eop_d = 3'b100;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_d = ser.bit_oe;
      if (ser.bit_se0) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          d_d   = 1'b1;
          se0_d = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!ser.bit_data) begin
        d_d = !d_q;
      end
      if (!oe_d) begin
        d_d = 1'b1;
      end
    end
  end

  assign dp_next = (cfg_pinflip_i ? ~d_d : d_d) & ~se0_d;
  assign dn_next = (cfg_pinflip_i ? d_d : ~d_d) & ~se0_d;

  assign usb_oe_o = oe_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= LsIdle;
      oe_q      <= 1'b0;
      d_q       <= 1'b1;
      se0_q     <= 1'b0;
      eop_q     <= '0;
      usb_d_o   <= 1'b1;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= 1'b1;
      usb_dn_o  <= 1'b0;
    end else if (link_reset_i) begin
      // Park at J on the selected pin orientation
      state_q   <= LsIdle;
      oe_q      <= 1'b0;
      d_q       <= 1'b1;
      se0_q     <= 1'b0;
      eop_q     <= '0;
      usb_d_o   <= ~cfg_pinflip_i;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= ~cfg_pinflip_i;
      usb_dn_o  <= cfg_pinflip_i;
    end else begin
      state_q   <= state_d;
      oe_q      <= oe_d;
      d_q       <= d_d;
      se0_q     <= se0_d;
      eop_q     <= eop_d;
      usb_d_o   <= dp_next;
      usb_se0_o <= se0_d;
      usb_dp_o  <= dp_next;
      usb_dn_o  <= dn_next;
    end
  end

endmodule

// ==== logic/usb_fs_tx_top.sv ====
/*
 * Full-speed USB packet transmitter, no receiver.
 * Queue payload bytes first, then pulse pkt_start_i while the framer is idle.
 */

`timescale 1ns/1ps

module usb_fs_tx_top import usb_tx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       wr_valid_i,
  input  logic [7:0] wr_data_i,
  output logic       full_o,
  input  logic       pkt_start_i,
  input  usb_pid_e   pid_i,
  input  logic       tx_osc_test_mode_i,
  input  logic       cfg_pinflip_i,
  output logic       usb_oe_o,
  output logic       usb_d_o,
  output logic       usb_se0_o,
  output logic       usb_dp_o,
  output logic       usb_dn_o,
  output logic       pkt_end_o
);

  logic       bit_strobe;
  logic       data_avail;
  logic       data_get;
  logic [7:0] data;

  usb_tx_serial_if ser_if ();

  usb_tx_bit_timer bit_timer_inst (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .restart_i    (pkt_start_i),
    .bit_strobe_o (bit_strobe)
  );

  usb_tx_byte_fifo byte_fifo_inst (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .wr_valid_i,
    .wr_data_i,
    .full_o,
    .rd_get_i   (data_get),
    .rd_avail_o (data_avail),
    .rd_data_o  (data)
  );

  usb_tx_framer framer_inst (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_i (bit_strobe),
    .pkt_start_i,
    .pid_i,
    .osc_test_i   (tx_osc_test_mode_i),
    .data_avail_i (data_avail),
    .data_i       (data),
    .data_get_o   (data_get),
    .pkt_end_o,
    .ser          (ser_if.framer)
  );

  usb_tx_line_driver line_driver_inst (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_i (bit_strobe),
    .cfg_pinflip_i,
    .ser          (ser_if.driver),
    .usb_oe_o,
    .usb_d_o,
    .usb_se0_o,
    .usb_dp_o,
    .usb_dn_o
  );

endmodule

// ==== tb/usb_tx_line_monitor.sv ====
/*
 * Decodes the pads back into bytes: NRZI, unstuffing and EOP detection.
 * Assumes the bit period stays fixed while a packet is on the line.
 */

`timescale 1ns/1ps

module usb_tx_line_monitor import usb_tx_pkg::*; (
  input logic clk_i,
  input logic usb_oe_i,
  input logic usb_dp_i,
  input logic usb_dn_i,
  input logic usb_se0_i,
  input logic flip_i
);

  // Results, read and cleared by the testbench
  logic [7:0] byte_buf [32];
  int         byte_cnt;
  int         eop_cnt;
  int         max_ones;
  int         se0_bad;

  task automatic decode_packet();
    logic       prev;
    logic       lvl;
    logic       bit_val;
    logic       se0_line;
    logic [7:0] sh;
    int         ones;
    int         run;
    int         se0s;
    int         nbits;
    bit         done;
    prev  = 1'b1;
    sh    = '0;
    ones  = 0;
    run   = 0;
    se0s  = 0;
    nbits = 0;
    done  = 1'b0;
    // Move from the start of the bit towards its middle
    @(negedge clk_i);
    while (!done) begin
      se0_line = !usb_dp_i && !usb_dn_i;
      if (usb_se0_i !== se0_line) begin
        se0_bad++;
      end
      lvl = flip_i ? usb_dn_i : usb_dp_i;
      if (se0_line) begin
        se0s++;
      end else if (se0s == 2 && lvl === 1'b1) begin
        // Two SE0 bits then J
        eop_cnt++;
        done = 1'b1;
      end else if (se0s != 0 || usb_oe_i !== 1'b1) begin
        // Aborted packet or malformed EOP
        done = 1'b1;
      end else begin
        bit_val = (lvl == prev);
        prev    = lvl;
        // Unchanged line levels in a row, stuffed bits included
        run = bit_val ? run + 1 : 0;
        if (run > max_ones) begin
          max_ones = run;
        end
        if (ones == 6) begin
          // Stuffed zero, dropped
          ones = 0;
        end else begin
          ones = bit_val ? ones + 1 : 0;
          sh = {bit_val, sh[7:1]};
          nbits++;
          if (nbits == 8) begin
            if (byte_cnt < 32) begin
              byte_buf[byte_cnt] = sh;
              byte_cnt++;
            end
            nbits = 0;
          end
        end
      end
      if (!done) begin
        repeat (BitDiv) @(negedge clk_i);
      end
    end
    while (usb_oe_i === 1'b1) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    byte_cnt = 0;
    eop_cnt  = 0;
    max_ones = 0;
    se0_bad  = 0;
    forever begin
      @(negedge clk_i);
      if (usb_oe_i === 1'b1) begin
        decode_packet();
      end
    end
  end

endmodule

// ==== tb/usb_tx_tb.sv ====
/*
 * Testbench for the USB full-speed transmitter. Packets are decoded from
 * the pads by the line monitor and checked against a reference builder.
 */

`timescale 1ns/1ps

module usb_tx_tb import usb_tx_pkg::*;;

  localparam int NumPkts     = 16;
  localparam int MaxPktBits  = 16 + (FifoDepth + 2) * 8 * 7 / 6 + 3 + 40;
  localparam int PktCycles   = MaxPktBits * BitDiv * 2;
  localparam int WatchdogNs  = 2 * NumPkts * MaxPktBits * BitDiv * 4;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       link_reset_i;
  logic       wr_valid_i;
  logic [7:0] wr_data_i;
  logic       full_o;
  logic       pkt_start_i;
  usb_pid_e   pid_i;
  logic       tx_osc_test_mode_i;
  logic       cfg_pinflip_i;
  logic       usb_oe_o;
  logic       usb_d_o;
  logic       usb_se0_o;
  logic       usb_dp_o;
  logic       usb_dn_o;
  logic       pkt_end_o;

  logic [19:0] lfsr_q;
  logic [7:0]  pay [FifoDepth + 2];
  logic [7:0]  exp_bytes [FifoDepth + 4];
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          err_at_start;
  int          end_cnt;

  always #2 clk_i = ~clk_i;

  usb_fs_tx_top usb_fs_tx_top_inst (.*);

  usb_tx_line_monitor usb_tx_line_monitor_inst (
    .clk_i,
    .usb_oe_i  (usb_oe_o),
    .usb_dp_i  (usb_dp_o),
    .usb_dn_i  (usb_dn_o),
    .usb_se0_i (usb_se0_o),
    .flip_i    (cfg_pinflip_i)
  );

  always @(negedge clk_i) begin
    if (pkt_end_o) begin
      end_cnt++;
    end
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and reference packet
  ////////////////////////////////////////////////////////////////////////////

  // Taps 20 and 17, one step per bit
  function automatic int rand_bits(int n);
    int r;
    logic fb;
    r = 0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[19] ^ lfsr_q[16];
      lfsr_q = {lfsr_q[18:0], fb};
      r      = (r << 1) | fb;
    end
    return r;
  endfunction

  // Expected bytes on the line, returns their count
  function automatic int build_expected(usb_pid_e pid, int n);
    logic [15:0] crc;
    logic        fb;
    int          k;
    exp_bytes[0] = SyncByte;
    exp_bytes[1] = {~pid, pid};
    k = 2;
    if (pid[1:0] == 2'b11) begin
      crc = Crc16Init;
      for (int i = 0; i < n; i++) begin
        exp_bytes[k] = pay[i];
        k++;
        for (int b = 0; b < 8; b++) begin
          fb  = pay[i][b] ^ crc[15];
          crc = {crc[14:0], 1'b0} ^ (fb ? Crc16Poly : 16'h0000);
        end
      end
      for (int b = 0; b < 8; b++) begin
        exp_bytes[k][b]     = ~crc[15 - b];
        exp_bytes[k + 1][b] = ~crc[7 - b];
      end
      k += 2;
    end
    return k;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_byte(string name, logic [7:0] exp, logic [7:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %02h actual %02h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic compare_pid(string name, usb_pid_e exp, usb_pid_e act);
    if (exp !== act) begin
      $display("ERR %s expected %s actual %04b", name, exp.name(), act);
      err_cnt++;
    end
  endtask

  task automatic compare_crc(string name, logic [15:0] exp, logic [15:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %04h actual %04h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic compare_level(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic begin_test();
    err_at_start = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test(string name);
    if (err_cnt == err_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed", name);
      fail_cnt++;
    end
  endtask

  task automatic write_bytes(int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      #1;
      wr_valid_i = 1'b1;
      wr_data_i  = pay[i];
    end
    @(posedge clk_i);
    #1;
    wr_valid_i = 1'b0;
  endtask

  task automatic start_packet(usb_pid_e pid);
    usb_tx_line_monitor_inst.byte_cnt = 0;
    usb_tx_line_monitor_inst.max_ones = 0;
    usb_tx_line_monitor_inst.se0_bad  = 0;
    end_cnt = 0;
    @(posedge clk_i);
    #1;
    pkt_start_i = 1'b1;
    pid_i       = pid;
    @(posedge clk_i);
    #1;
    pkt_start_i = 1'b0;
  endtask

  // Sends one packet and checks the decoded bytes, n_exp payload bytes
  task automatic run_packet(string name, usb_pid_e pid, int n_wr, int n_exp);
    int n;
    int eop_before;
    int cycles;
    begin_test();
    compare_level({name, " idle oe"}, 1'b0, usb_oe_o);
    compare_level({name, " idle dp"}, ~cfg_pinflip_i, usb_dp_o);
    compare_level({name, " idle d"}, ~cfg_pinflip_i, usb_d_o);
    compare_level({name, " idle se0"}, 1'b0, usb_se0_o);
    write_bytes(n_wr);
    eop_before = usb_tx_line_monitor_inst.eop_cnt;
    start_packet(pid);
    cycles = 0;
    while (usb_tx_line_monitor_inst.eop_cnt == eop_before && cycles < PktCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    repeat (4 * BitDiv) @(negedge clk_i);
    if (usb_tx_line_monitor_inst.eop_cnt == eop_before) begin
      $display("%s: no EOP was seen on the line", name);
      err_cnt++;
    end
    if (end_cnt != 1) begin
      $display("%s: pkt_end_o pulsed %0d times instead of once", name, end_cnt);
      err_cnt++;
    end
    if (usb_tx_line_monitor_inst.se0_bad != 0) begin
      $display("%s: usb_se0_o disagreed with the D+/D- levels", name);
      err_cnt++;
    end
    n = build_expected(pid, n_exp);
    if (usb_tx_line_monitor_inst.byte_cnt != n) begin
      $display("%s: decoded %0d bytes but expected %0d", name,
               usb_tx_line_monitor_inst.byte_cnt, n);
      err_cnt++;
    end else begin
      compare_pid({name, " pid"}, pid, usb_pid_e'(usb_tx_line_monitor_inst.byte_buf[1][3:0]));
      for (int i = 0; i < n; i++) begin
        compare_byte($sformatf("%s byte %0d", name, i), exp_bytes[i],
                     usb_tx_line_monitor_inst.byte_buf[i]);
      end
      if (n > 2) begin
        compare_crc({name, " crc"}, {exp_bytes[n - 2], exp_bytes[n - 1]},
                    {usb_tx_line_monitor_inst.byte_buf[n - 2],
                     usb_tx_line_monitor_inst.byte_buf[n - 1]});
      end
    end
    if (usb_tx_line_monitor_inst.max_ones > 6) begin
      $display("%s: more than six ones in a row without a stuffed zero", name);
      err_cnt++;
    end
    end_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int   len;
    int   cycles;
    logic prev;
    rst_ni             = 1'b0;
    link_reset_i       = 1'b0;
    wr_valid_i         = 1'b0;
    wr_data_i          = '0;
    pkt_start_i        = 1'b0;
    pid_i              = Ack;
    tx_osc_test_mode_i = 1'b0;
    cfg_pinflip_i      = 1'b0;
    lfsr_q             = 20'd98008;
    err_cnt            = 0;
    test_cnt           = 0;
    fail_cnt           = 0;
    end_cnt            = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test();
    compare_level("reset oe", 1'b0, usb_oe_o);
    compare_level("reset dp", 1'b1, usb_dp_o);
    compare_level("reset d", 1'b1, usb_d_o);
    compare_level("reset se0", 1'b0, usb_se0_o);
    end_test("reset idle");

    run_packet("ack", Ack, 0, 0);
    run_packet("nak", Nak, 0, 0);
    run_packet("in", In, 0, 0);
    run_packet("data0 empty", Data0, 0, 0);

    for (int t = 0; t < 6; t++) begin
      len = rand_bits(4) % (FifoDepth + 1);
      for (int i = 0; i < len; i++) begin
        pay[i] = 8'(rand_bits(8));
      end
      run_packet($sformatf("data random %0d", t), (t % 2) ? Data1 : Data0, len, len);
    end

    for (int i = 0; i < FifoDepth; i++) begin
      pay[i] = 8'hFF;
    end
    run_packet("data all ones", Data1, FifoDepth, FifoDepth);

    // Swapped pins
    @(posedge clk_i);
    #1;
    cfg_pinflip_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    begin_test();
    compare_level("flip idle dn", 1'b1, usb_dn_o);
    compare_level("flip idle dp", 1'b0, usb_dp_o);
    end_test("pinflip idle");
    for (int i = 0; i < 5; i++) begin
      pay[i] = 8'(rand_bits(8));
    end
    run_packet("pinflip data", Data1, 5, 5);
    @(posedge clk_i);
    #1;
    cfg_pinflip_i = 1'b0;
    repeat (2) @(posedge clk_i);

    // Queue overflow, the last two writes are dropped
    for (int i = 0; i < FifoDepth + 2; i++) begin
      pay[i] = 8'(rand_bits(8));
    end
    begin_test();
    write_bytes(FifoDepth + 2);
    compare_level("full after overflow", 1'b1, full_o);
    end_test("queue full");
    run_packet("full data", Data0, 0, FifoDepth);

    // Oscillator test, line toggles every bit time
    begin_test();
    @(posedge clk_i);
    #1;
    tx_osc_test_mode_i = 1'b1;
    cycles = 0;
    while (usb_oe_o !== 1'b1 && cycles < 64 * BitDiv) begin
      @(negedge clk_i);
      cycles++;
    end
    prev = usb_dp_o;
    while (usb_dp_o === prev && cycles < 64 * BitDiv) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= 64 * BitDiv) begin
      $display("osc test: line never started toggling");
      err_cnt++;
    end
    repeat (2) @(negedge clk_i);
    prev = usb_dp_o;
    for (int i = 0; i < 8; i++) begin
      repeat (BitDiv) @(negedge clk_i);
      compare_level("osc oe", 1'b1, usb_oe_o);
      compare_level($sformatf("osc dp bit %0d", i), ~prev, usb_dp_o);
      prev = usb_dp_o;
    end
    @(posedge clk_i);
    #1;
    tx_osc_test_mode_i = 1'b0;
    repeat (20 * BitDiv) @(negedge clk_i);
    compare_level("osc off oe", 1'b0, usb_oe_o);
    end_test("osc test");

    // Link reset in the middle of a packet
    begin_test();
    for (int i = 0; i < FifoDepth; i++) begin
      pay[i] = 8'(rand_bits(8));
    end
    write_bytes(FifoDepth);
    start_packet(Data0);
    cycles = 0;
    while (usb_tx_line_monitor_inst.byte_cnt < 4 && cycles < PktCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    @(posedge clk_i);
    #1;
    link_reset_i = 1'b1;
    @(posedge clk_i);
    #1;
    link_reset_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    compare_level("link reset oe", 1'b0, usb_oe_o);
    compare_level("link reset full", 1'b0, full_o);
    repeat (8 * BitDiv) @(negedge clk_i);
    if (end_cnt != 0) begin
      $display("link reset: pkt_end_o pulsed for an aborted packet");
      err_cnt++;
    end
    end_test("link reset");
    for (int i = 0; i < 3; i++) begin
      pay[i] = 8'(rand_bits(8));
    end
    run_packet("after link reset", Data1, 3, 3);

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== src.f ====
logic/usb_tx_pkg.sv
logic/usb_tx_serial_if.sv
logic/usb_tx_bit_timer.sv
logic/usb_tx_byte_fifo.sv
logic/usb_tx_framer.sv
logic/usb_tx_line_driver.sv
logic/usb_fs_tx_top.sv
tb/usb_tx_line_monitor.sv
tb/usb_tx_tb.sv

// ==== Bender.yml ====
package:
  name: usb_fs_tx

sources:
  - logic/usb_tx_pkg.sv
  - logic/usb_tx_serial_if.sv
  - logic/usb_tx_bit_timer.sv
  - logic/usb_tx_byte_fifo.sv
  - logic/usb_tx_framer.sv
  - logic/usb_tx_line_driver.sv
  - logic/usb_fs_tx_top.sv
  - target: test
    files:
      - tb/usb_tx_line_monitor.sv
      - tb/usb_tx_tb.sv
